// ==== rtl/cache_lookup_top.sv ====
module cache_lookup_top (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  cache_pkg::port_req_t [cache_pkg::NR_PORTS-1:0] req_i,
    output cache_pkg::port_rsp_t [cache_pkg::NR_PORTS-1:0] rsp_o,
    output logic [cache_pkg::NR_PORTS-1:0]               busy_o
);
    import cache_pkg::*;

    // ------------------------------
    // port units to tag compare
    // ------------------------------
    logic [NR_PORTS-1:0][SET_ASSOC-1:0]  port_way_req;
    logic [NR_PORTS-1:0][ADDR_WIDTH-1:0] port_addr;
    cache_line_t [NR_PORTS-1:0]          port_wdata;
    logic [NR_PORTS-1:0]                 port_we;
    line_be_t [NR_PORTS-1:0]             port_be;
    logic [NR_PORTS-1:0][TAG_WIDTH-1:0]  port_tag;
    logic [NR_PORTS-1:0]                 port_gnt;
    cache_line_t [SET_ASSOC-1:0]         shared_rdata;
    logic [SET_ASSOC-1:0]                hit_way;

    // tag compare to way rams
    logic [SET_ASSOC-1:0]                ram_req;
    logic [ADDR_WIDTH-1:0]               ram_addr;
    cache_line_t                         ram_wdata;
    logic                                ram_we;
    line_be_t                            ram_be;
    cache_line_t [SET_ASSOC-1:0]         ram_rdata;

    for (genvar p = 0; p < NR_PORTS; p++) begin : gen_port
        lookup_port i_lookup_port (
            .clk_i     ( clk_i           ),
            .rst_ni    ( rst_ni          ),
            .req_i     ( req_i[p]        ),
            .rsp_o     ( rsp_o[p]        ),
            .busy_o    ( busy_o[p]       ),
            .way_req_o ( port_way_req[p] ),
            .addr_o    ( port_addr[p]    ),
            .wdata_o   ( port_wdata[p]   ),
            .we_o      ( port_we[p]      ),
            .be_o      ( port_be[p]      ),
            .tag_o     ( port_tag[p]     ),
            .gnt_i     ( port_gnt[p]     ),
            .rdata_i   ( shared_rdata    ),
            .hit_way_i ( hit_way         )
        );
    end

    tag_cmp i_tag_cmp (
        .clk_i     ( clk_i        ),
        .rst_ni    ( rst_ni       ),
        .req_i     ( port_way_req ),
        .gnt_o     ( port_gnt     ),
        .addr_i    ( port_addr    ),
        .wdata_i   ( port_wdata   ),
        .we_i      ( port_we      ),
        .be_i      ( port_be      ),
        .tag_i     ( port_tag     ),
        .rdata_o   ( shared_rdata ),
        .hit_way_o ( hit_way      ),
        .req_o     ( ram_req      ),
        .addr_o    ( ram_addr     ),
        .wdata_o   ( ram_wdata    ),
        .we_o      ( ram_we       ),
        .be_o      ( ram_be       ),
        .rdata_i   ( ram_rdata    )
    );

    // one single-port ram per way, all share the winner's fields
    for (genvar w = 0; w < SET_ASSOC; w++) begin : gen_way
        way_ram i_way_ram (
            .clk_i   ( clk_i        ),
            .rst_ni  ( rst_ni       ),
            .req_i   ( ram_req[w]   ),
            .we_i    ( ram_we       ),
            .addr_i  ( ram_addr     ),
            .wdata_i ( ram_wdata    ),
            .be_i    ( ram_be       ),
            .rdata_o ( ram_rdata[w] )
        );
    end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // ------------------------------
    // cache geometry
    // ------------------------------
    localparam int unsigned NR_PORTS     = 3;
    localparam int unsigned SET_ASSOC    = 4;
    localparam int unsigned ADDR_WIDTH   = 16;
    localparam int unsigned INDEX_WIDTH  = 4;
    localparam int unsigned NR_SETS      = 2 ** INDEX_WIDTH;
    localparam int unsigned LINE_BYTES   = 4;
    localparam int unsigned OFFSET_WIDTH = $clog2(LINE_BYTES);
    // address layout is tag | index | byte offset
    localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned WAY_WIDTH    = $clog2(SET_ASSOC);
    localparam int unsigned DATA_WIDTH   = 8 * LINE_BYTES;

    // ------------------------------
    // line and port types
    // ------------------------------
    typedef enum logic {
        OP_LOOKUP = 1'b0,
        OP_FILL   = 1'b1
    } port_op_e;

    // one stored line, valid in the msb
    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } cache_line_t;

    // one enable per data byte
    typedef logic [LINE_BYTES-1:0] line_be_t;

    typedef struct packed {
        logic                  valid;
        port_op_e              op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WAY_WIDTH-1:0]  way;
        logic [DATA_WIDTH-1:0] data;
        line_be_t              be;
    } port_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  hit;
        logic [WAY_WIDTH-1:0]  way;
        logic [DATA_WIDTH-1:0] data;
    } port_rsp_t;

endpackage

// ==== rtl/lookup_port.sv ====
module lookup_port (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    // requester side
    input  cache_pkg::port_req_t                              req_i,
    output cache_pkg::port_rsp_t                              rsp_o,
    output logic                                              busy_o,
    // towards the tag compare
    output logic [cache_pkg::SET_ASSOC-1:0]                   way_req_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                  addr_o,
    output cache_pkg::cache_line_t                            wdata_o,
    output logic                                              we_o,
    output cache_pkg::line_be_t                               be_o,
    output logic [cache_pkg::TAG_WIDTH-1:0]                   tag_o,
    input  logic                                              gnt_i,
    input  cache_pkg::cache_line_t [cache_pkg::SET_ASSOC-1:0] rdata_i,
    input  logic [cache_pkg::SET_ASSOC-1:0]                   hit_way_i
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        TAG_PHASE
    } state_e;

    state_e                state_d;
    state_e                state_q;
    port_req_t             req_q;
    logic [TAG_WIDTH-1:0]  req_tag;
    logic [WAY_WIDTH-1:0]  hit_idx;
    logic                  lookup_hit;
    // response registers
    logic                  rsp_valid_q;
    logic                  rsp_hit_q;
    logic [WAY_WIDTH-1:0]  rsp_way_q;
    logic [DATA_WIDTH-1:0] rsp_data_q;

    // ------------------------------
    // request side
    // ------------------------------
    assign req_tag = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign busy_o  = (state_q != IDLE);
    assign addr_o  = req_q.addr;
    assign we_o    = (req_q.op == OP_FILL);
    assign be_o    = req_q.be;
    // a fill always marks the line valid under its own tag
    assign wdata_o = '{valid: 1'b1, tag: req_tag, data: req_q.data};
    // tag only shows up in the cycle after the grant
    assign tag_o   = (state_q == TAG_PHASE) ? req_tag : '0;

    always_comb begin : way_sel
        way_req_o = '0;
        if (state_q == WAIT_GNT) begin
            if (req_q.op == OP_FILL) begin
                way_req_o[req_q.way] = 1'b1;
            end else begin
                way_req_o = '1;
            end
        end
    end

    always_comb begin : fsm
        state_d = state_q;
        case (state_q)
            IDLE:      if (req_i.valid) state_d = WAIT_GNT;
            // keep asking while a higher port wins
            WAIT_GNT:  if (gnt_i) state_d = TAG_PHASE;
            TAG_PHASE: state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_q <= (state_q == TAG_PHASE);
        end
    end

    // ------------------------------
    // response side
    // ------------------------------
    // hit vector is at most one-hot, so a plain encoder is enough
    always_comb begin : hit_enc
        hit_idx = '0;
        for (int unsigned j = 0; j < SET_ASSOC; j++) begin
            if (hit_way_i[j]) begin
                hit_idx = WAY_WIDTH'(j);
            end
        end
    end

    // fills complete with hit low
    assign lookup_hit = (req_q.op == OP_LOOKUP) && (|hit_way_i);

    always_ff @(posedge clk_i) begin
        if (state_q == TAG_PHASE) begin
            rsp_hit_q  <= lookup_hit;
            rsp_way_q  <= lookup_hit ? hit_idx : '0;
            rsp_data_q <= lookup_hit ? rdata_i[hit_idx].data : '0;
        end else if ((state_q == IDLE) && req_i.valid) begin
            req_q <= req_i;
        end
    end

    assign rsp_o = '{valid: rsp_valid_q, hit: rsp_hit_q, way: rsp_way_q, data: rsp_data_q};

endmodule

// ==== rtl/tag_cmp.sv ====
module tag_cmp #(
    parameter int unsigned ADDR_WIDTH = cache_pkg::ADDR_WIDTH
) (
    input  logic                                                     clk_i,
    input  logic                                                     rst_ni,
    // port side
    input  logic [cache_pkg::NR_PORTS-1:0][cache_pkg::SET_ASSOC-1:0] req_i,
    output logic [cache_pkg::NR_PORTS-1:0]                           gnt_o,
    input  logic [cache_pkg::NR_PORTS-1:0][ADDR_WIDTH-1:0]           addr_i,
    input  cache_pkg::cache_line_t [cache_pkg::NR_PORTS-1:0]         wdata_i,
    input  logic [cache_pkg::NR_PORTS-1:0]                           we_i,
    input  cache_pkg::line_be_t [cache_pkg::NR_PORTS-1:0]            be_i,
    input  logic [cache_pkg::NR_PORTS-1:0][cache_pkg::TAG_WIDTH-1:0] tag_i,
    output cache_pkg::cache_line_t [cache_pkg::SET_ASSOC-1:0]        rdata_o,
    output logic [cache_pkg::SET_ASSOC-1:0]                          hit_way_o,
    // way ram side
    output logic [cache_pkg::SET_ASSOC-1:0]                          req_o,
    output logic [ADDR_WIDTH-1:0]                                    addr_o,
    output cache_pkg::cache_line_t                                   wdata_o,
    output logic                                                     we_o,
    output cache_pkg::line_be_t                                      be_o,
    input  cache_pkg::cache_line_t [cache_pkg::SET_ASSOC-1:0]        rdata_i
);
    import cache_pkg::*;

    // winner of the current cycle and of the previous one, one-hot
    logic [NR_PORTS-1:0]  id_d;
    logic [NR_PORTS-1:0]  id_q;
    logic [TAG_WIDTH-1:0] sel_tag;
    logic                 found;

    // all ports see the same read data
    assign rdata_o = rdata_i;

    // ------------------------------
    // fixed priority arbiter
    // ------------------------------
    always_comb begin : arbiter
        found   = 1'b0;
        gnt_o   = '0;
        id_d    = '0;
        req_o   = '0;
        addr_o  = '0;
        wdata_o = '0;
        we_o    = 1'b0;
        be_o    = '0;
        // lowest index that requests any way wins
        for (int unsigned i = 0; i < NR_PORTS; i++) begin
            if (!found && (|req_i[i])) begin
                found    = 1'b1;
                gnt_o[i] = 1'b1;
                id_d[i]  = 1'b1;
                req_o    = req_i[i];
                addr_o   = addr_i[i];
                wdata_o  = wdata_i[i];
                we_o     = we_i[i];
                be_o     = be_i[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_q <= '0;
        end else begin
            id_q <= id_d;
        end
    end

    // ------------------------------
    // tag compare
    // ------------------------------
    // tag arrives one cycle after the grant, together with the ram data
    always_comb begin : tag_sel
        sel_tag = '0;
        for (int unsigned i = 0; i < NR_PORTS; i++) begin
            if (id_q[i]) begin
                sel_tag = tag_i[i];
            end
        end
    end

    for (genvar j = 0; j < SET_ASSOC; j++) begin : gen_hit
        // no winner last cycle means nothing to compare
        assign hit_way_o[j] = (|id_q) && rdata_i[j].valid && (rdata_i[j].tag == sel_tag);
    end

endmodule

// ==== rtl/way_ram.sv ====
module way_ram #(
    parameter int unsigned ADDR_WIDTH = cache_pkg::ADDR_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic [ADDR_WIDTH-1:0]  addr_i,
    input  cache_pkg::cache_line_t wdata_i,
    input  cache_pkg::line_be_t    be_i,
    output cache_pkg::cache_line_t rdata_o
);
    import cache_pkg::*;

    logic [INDEX_WIDTH-1:0]     index;
    logic [NR_SETS-1:0]         valid_q;
    logic [TAG_WIDTH-1:0]       tag_mem  [NR_SETS];
    logic [LINE_BYTES-1:0][7:0] data_mem [NR_SETS];
    // read port registers
    logic                       rd_valid_q;
    logic [TAG_WIDTH-1:0]       rd_tag_q;
    logic [LINE_BYTES-1:0][7:0] rd_data_q;

    assign index = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];

    // valid bits sit in flops, reset invalidates every set
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else if (req_i) begin
            if (we_i) begin
                valid_q[index] <= wdata_i.valid;
            end else begin
                rd_valid_q <= valid_q[index];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                // tag always written, data only where enabled
                tag_mem[index] <= wdata_i.tag;
                for (int unsigned b = 0; b < LINE_BYTES; b++) begin
                    if (be_i[b]) begin
                        data_mem[index][b] <= wdata_i.data[8*b +: 8];
                    end
                end
            end else begin
                rd_tag_q  <= tag_mem[index];
                rd_data_q <= data_mem[index];
            end
        end
    end

    assign rdata_o = {rd_valid_q, rd_tag_q, rd_data_q};

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cache lookup testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_cache_lookup -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_cache_lookup" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "simulation ended without a result line"
    echo "RESULT: FAIL"
    exit 1
fi

echo "RESULT: PASS"
exit 0

// ==== src.f ====
rtl/cache_pkg.sv
rtl/tag_cmp.sv
rtl/way_ram.sv
rtl/lookup_port.sv
rtl/cache_lookup_top.sv
test/cache_lookup_asserts.sv
test/tb_cache_lookup.sv

// ==== test/cache_lookup_asserts.sv ====
module cache_lookup_asserts (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  cache_pkg::port_req_t [cache_pkg::NR_PORTS-1:0] req_i,
    input  cache_pkg::port_rsp_t [cache_pkg::NR_PORTS-1:0] rsp_i,
    input  logic [cache_pkg::NR_PORTS-1:0]                 busy_i,
    input  logic [cache_pkg::NR_PORTS-1:0]                 gnt_i,
    input  logic [cache_pkg::SET_ASSOC-1:0]                hit_way_i,
    input  logic [cache_pkg::SET_ASSOC-1:0]                ram_req_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    // count of failed assertions
    int unsigned              err_cnt = 0;
    // shadow of every line in every way
    cache_line_t              shadow_q [SET_ASSOC][NR_SETS];
    // accepted request of each port, and which ones still wait for the arbiter
    port_req_t [NR_PORTS-1:0] open_req_q;
    logic [NR_PORTS-1:0]      wait_q;
    logic [NR_PORTS-1:0]      exp_gnt;
    port_req_t                win_req;
    logic [INDEX_WIDTH-1:0]   index;
    logic [TAG_WIDTH-1:0]     tag;
    logic                     rst_q;
    logic [NR_PORTS-1:0]      rsp_valid;
    logic [NR_PORTS-1:0]      gnt_q1;
    logic [NR_PORTS-1:0]      gnt_q2;
    // expected lookup result, follows the winner down the pipe
    logic                     exp_hit_d;
    logic                     exp_hit_q1;
    logic                     exp_hit_q2;
    logic [WAY_WIDTH-1:0]     exp_way_d;
    logic [WAY_WIDTH-1:0]     exp_way_q1;
    logic [WAY_WIDTH-1:0]     exp_way_q2;
    logic [DATA_WIDTH-1:0]    exp_data_d;
    logic [DATA_WIDTH-1:0]    exp_data_q1;
    logic [DATA_WIDTH-1:0]    exp_data_q2;

    always_comb begin : rsp_collect
        for (int unsigned p = 0; p < NR_PORTS; p++) begin
            rsp_valid[p] = rsp_i[p].valid;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    // lowest set bit of the waiting ports wins
    assign exp_gnt = wait_q & (~wait_q + 1'b1);

    always_comb begin : winner_sel
        win_req = '0;
        for (int unsigned p = 0; p < NR_PORTS; p++) begin
            if (exp_gnt[p]) begin
                win_req = open_req_q[p];
            end
        end
    end

    assign index = win_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag   = win_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    // lookup of the winner against the shadow as it stands in the grant cycle
    always_comb begin : expect_lookup
        exp_hit_d  = 1'b0;
        exp_way_d  = '0;
        exp_data_d = '0;
        if ((exp_gnt != '0) && (win_req.op == OP_LOOKUP)) begin
            for (int unsigned w = 0; w < SET_ASSOC; w++) begin
                if (shadow_q[w][index].valid && (shadow_q[w][index].tag == tag)) begin
                    exp_hit_d  = 1'b1;
                    exp_way_d  = WAY_WIDTH'(w);
                    exp_data_d = shadow_q[w][index].data;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned w = 0; w < SET_ASSOC; w++) begin
                for (int unsigned s = 0; s < NR_SETS; s++) begin
                    shadow_q[w][s] <= '0;
                end
            end
            rst_q       <= 1'b0;
            open_req_q  <= '0;
            wait_q      <= '0;
            gnt_q1      <= '0;
            gnt_q2      <= '0;
            exp_hit_q1  <= 1'b0;
            exp_hit_q2  <= 1'b0;
            exp_way_q1  <= '0;
            exp_way_q2  <= '0;
            exp_data_q1 <= '0;
            exp_data_q2 <= '0;
        end else begin
            rst_q       <= 1'b1;
            gnt_q1      <= exp_gnt;
            gnt_q2      <= gnt_q1;
            exp_hit_q1  <= exp_hit_d;
            exp_hit_q2  <= exp_hit_q1;
            exp_way_q1  <= exp_way_d;
            exp_way_q2  <= exp_way_q1;
            exp_data_q1 <= exp_data_d;
            exp_data_q2 <= exp_data_q1;
            // fill merges enabled bytes into the chosen way, tag and valid always taken
            if ((exp_gnt != '0) && (win_req.op == OP_FILL)) begin
                shadow_q[win_req.way][index].valid <= 1'b1;
                shadow_q[win_req.way][index].tag   <= tag;
                for (int unsigned b = 0; b < LINE_BYTES; b++) begin
                    if (win_req.be[b]) begin
                        shadow_q[win_req.way][index].data[8*b +: 8] <= win_req.data[8*b +: 8];
                    end
                end
            end
            // a new request in the response cycle starts a fresh wait
            for (int unsigned p = 0; p < NR_PORTS; p++) begin
                if (req_i[p].valid && !busy_i[p]) begin
                    open_req_q[p] <= req_i[p];
                    wait_q[p]     <= 1'b1;
                end else if (exp_gnt[p]) begin
                    wait_q[p] <= 1'b0;
                end
            end
        end
    end

    // ------------------------------
    // per port checks
    // ------------------------------
    for (genvar p = 0; p < NR_PORTS; p++) begin : gen_port_chk
        a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_i[p].valid == gnt_q2[p])
            else begin
                err_cnt++;
                $error("mismatch %0t: port %0d response not 2 cycles after its grant", $time, p);
            end

        a_rsp_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_i[p].valid |-> (rsp_i[p].hit == exp_hit_q2) && (!exp_hit_q2 ||
                ((rsp_i[p].way == exp_way_q2) && (rsp_i[p].data == exp_data_q2))))
            else begin
                err_cnt++;
                $error("mismatch %0t: port %0d hit, way or data differs from shadow", $time, p);
            end

        a_busy_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_i[p].valid |-> !busy_i[p])
            else begin
                err_cnt++;
                $error("port %0d still busy in its response cycle at %0t", p, $time);
            end
    end

    // ------------------------------
    // shared checks
    // ------------------------------
    a_gnt_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_i == exp_gnt)
        else begin
            err_cnt++;
            $error("mismatch %0t: grant %b, expected %b", $time, gnt_i, exp_gnt);
        end

    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_way_i))
        else begin
            err_cnt++;
            $error("mismatch %0t: hit vector %b has more than one way set", $time, hit_way_i);
        end

    // quiet in reset and in the first cycle after it
    a_reset_quiet: assert property (@(posedge clk_i)
        !(rst_ni && rst_q) |-> (rsp_valid == '0) && (busy_i == '0) && (ram_req_i == '0))
        else begin
            err_cnt++;
            $error("response, busy or ram request high around reset at %0t", $time);
        end

endmodule

bind cache_lookup_top cache_lookup_asserts u_checker (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .req_i     ( req_i    ),
    .rsp_i     ( rsp_o    ),
    .busy_i    ( busy_o   ),
    .gnt_i     ( port_gnt ),
    .hit_way_i ( hit_way  ),
    .ram_req_i ( ram_req  )
);

// ==== test/tb_cache_lookup.sv ====
module tb_cache_lookup;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int unsigned WAIT_LIMIT = 64;
    // flips the tag bits above the way bits
    localparam logic [TAG_WIDTH-1:0] TAG_FLIP = {{(TAG_WIDTH-WAY_WIDTH){1'b1}}, {WAY_WIDTH{1'b0}}};

    logic                     clk_i;
    logic                     rst_ni;
    port_req_t [NR_PORTS-1:0] req;
    port_rsp_t [NR_PORTS-1:0] rsp;
    logic [NR_PORTS-1:0]      busy;
    integer                   seed;
    // lines written at least once, per way
    logic [NR_SETS-1:0]       filled [SET_ASSOC];

    cache_lookup_top dut (
        .clk_i  ( clk_i  ),
        .rst_ni ( rst_ni ),
        .req_i  ( req    ),
        .rsp_o  ( rsp    ),
        .busy_o ( busy   )
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                        input logic [INDEX_WIDTH-1:0] idx);
        return {tag, idx, {OFFSET_WIDTH{1'b0}}};
    endfunction

    // raise a request on port p, it goes out with the next step
    task automatic set_req(input int unsigned p, input port_op_e op,
                           input logic [ADDR_WIDTH-1:0] addr, input logic [WAY_WIDTH-1:0] way,
                           input line_be_t be);
        logic [INDEX_WIDTH-1:0] idx;
        line_be_t               be_v;
        idx  = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        be_v = be;
        if (op == OP_FILL) begin
            // first fill of a line writes every byte
            if (!filled[way][idx]) begin
                be_v = '1;
            end
            filled[way][idx] = 1'b1;
        end
        req[p].valid = 1'b1;
        req[p].op    = op;
        req[p].addr  = addr;
        req[p].way   = way;
        req[p].data  = $random(seed);
        req[p].be    = be_v;
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
        for (int unsigned p = 0; p < NR_PORTS; p++) begin
            req[p].valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        int unsigned cnt;
        cnt = 0;
        while ((busy != '0) && (cnt < WAIT_LIMIT)) begin
            @(posedge clk_i);
            #1;
            cnt++;
        end
        if (busy != '0) begin
            fail_now($sformatf("%0t: ports still busy after %0d cycles", $time, WAIT_LIMIT));
        end
    endtask

    always @(posedge clk_i) begin : error_watch
        if (dut.u_checker.err_cnt != 0) begin
            fail_now($sformatf("%0t: a checker assertion failed", $time));
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus
        int unsigned            p;
        logic [31:0]            r;
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] idx;
        logic [WAY_WIDTH-1:0]   way;
        seed   = 32'hdef4;
        rst_ni = 1'b0;
        req    = '0;
        tag    = '0;
        idx    = '0;
        for (int unsigned w = 0; w < SET_ASSOC; w++) begin
            filled[w] = '0;
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // all ports look up at once on an empty cache
        for (p = 0; p < NR_PORTS; p++) begin
            r = $random(seed);
            set_req(p, OP_LOOKUP, r[ADDR_WIDTH-1:0], '0, '0);
        end
        step();
        wait_idle();

        // fill, hit on the same address, miss on a foreign tag
        for (int unsigned n = 0; n < 16; n++) begin
            r   = $random(seed);
            way = r[WAY_WIDTH-1:0];
            idx = r[8 +: INDEX_WIDTH];
            // low tag bits equal the way, so no set holds a tag twice
            tag = {r[16 +: TAG_WIDTH-WAY_WIDTH], way};
            set_req(n % NR_PORTS, OP_FILL, make_addr(tag, idx), way, r[28 +: LINE_BYTES]);
            step();
            wait_idle();
            set_req((n + 1) % NR_PORTS, OP_LOOKUP, make_addr(tag, idx), '0, '0);
            step();
            wait_idle();
            set_req((n + 2) % NR_PORTS, OP_LOOKUP, make_addr(tag ^ TAG_FLIP, idx), '0, '0);
            step();
            wait_idle();
        end

        // contention, port 0 hits the last filled line
        for (int unsigned n = 0; n < 8; n++) begin
            for (p = 0; p < NR_PORTS; p++) begin
                r = $random(seed);
                set_req(p, OP_LOOKUP, (p == 0) ? make_addr(tag, idx) : r[ADDR_WIDTH-1:0],
                        '0, '0);
            end
            step();
            wait_idle();
        end

        // random traffic on a narrow address space for many hits
        for (int unsigned c = 0; c < 200; c++) begin
            for (p = 0; p < NR_PORTS; p++) begin
                r = $random(seed);
                if (!busy[p] && r[0]) begin
                    way = r[2:1];
                    idx = {{(INDEX_WIDTH-2){1'b0}}, r[4:3]};
                    tag = {{(TAG_WIDTH-WAY_WIDTH-2){1'b0}}, r[8:7], way};
                    set_req(p, r[9] ? OP_FILL : OP_LOOKUP, make_addr(tag, idx), way, r[13:10]);
                end
            end
            step();
        end
        wait_idle();

        // let the checker sample the last response
        repeat (2) @(posedge clk_i);
        if (dut.u_checker.err_cnt != 0) begin
            $display("%0t: checker reported errors", $time);
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
